//--- design/busSizingPkg.sv
//////////////////////////////////////////////////////////////////////
// Shared encodings, FIFO depths and beat payloads for the bus sizer
// Byte-port acknowledge (dsack 10) has no code and reads as wait
//////////////////////////////////////////////////////////////////////

package busSizingPkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int dataWidth = 32;              // Full local bus
    localparam int halfWidth = 16;              // One 16-bit port word

    // Transfer size codes as driven on siz by the CPU
    localparam logic [1:0] sizLong = 2'b00;
    localparam logic [1:0] sizByte = 2'b01;
    localparam logic [1:0] sizWord = 2'b10;
    localparam logic [1:0] sizLine = 2'b11;

    // Port-size acknowledge codes returned by the target
    localparam logic [1:0] dsackLong = 2'b00;   // 32-bit port
    localparam logic [1:0] dsackWord = 2'b01;   // 16-bit port
    localparam logic [1:0] dsackWait = 2'b11;   // Not yet terminated

    //////////////////////////////////////////////////////////////////////
    // Line beat counting
    //////////////////////////////////////////////////////////////////////

    localparam int lineBeats    = 4;
    localparam int lineCntWidth = $clog2(lineBeats);

    typedef logic [lineCntWidth-1:0] lineCount_t;

    localparam lineCount_t lastLineBeat = lineCount_t'(lineBeats - 1);

    // Staging depths
    localparam int ackDepth = 4;                // Whole line of read beats
    localparam int wrDepth  = 2;                // Pending write plus the next one

    //////////////////////////////////////////////////////////////////////
    // Beat payloads
    //////////////////////////////////////////////////////////////////////

    // One entry per CPU acknowledge
    typedef struct packed {
        logic [dataWidth-1:0] data;             // Zero on writes
        logic                 inhibit;          // Drives nTbi low with this nTa
    } readBeat_t;

    // CPU write word with the attributes needed for lane steering
    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic [1:0]           siz;
        logic [1:0]           addr;
    } writeBeat_t;

endpackage

//--- design/stagingFifo.sv
//////////////////////////////////////////////////////////////////////
// Small FIFO with no back-pressure; depth must be at least 2
// Head entry is visible in the same cycle it becomes valid
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stagingFifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 2
) (
    input  logic     BCLK,
    input  logic     nRESET,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t headData,
    output logic     empty,
    output logic     full
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] count_t;

    payload_t mem [depth];   // Entry storage
    ptr_t     wrPtr;
    ptr_t     rdPtr;
    count_t   count;         // Occupancy

    // Wrap works for any depth, not only powers of two
    function automatic ptr_t nextPtr(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr_t'(ptr + 1'b1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (pop)
                rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or simultaneous push and pop
            endcase
        end
    end

    always_ff @(posedge BCLK) begin
        if (push)
            mem[wrPtr] <= pushData;
    end

    assign headData = mem[rdPtr];
    assign empty    = (count == '0);
    assign full     = (count == count_t'(depth));

    // Producer cannot be stalled, so depth has to cover the worst case
    assert property (@(posedge BCLK) disable iff (!nRESET) push |-> !full)
        else $error("Push into full FIFO");

    assert property (@(posedge BCLK) disable iff (!nRESET) pop |-> !empty)
        else $error("Pop from empty FIFO");

endmodule

//--- design/cycleSequencer.sv
//////////////////////////////////////////////////////////////////////
// Target cycle control; long cycles to 16-bit ports split in two
// Line cycles expect 32-bit ports and carry a single buffered write word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cycleSequencer
    import busSizingPkg::*;
(
    input  logic                 BCLK,
    input  logic                 nRESET,
    input  logic                 nTs,        // CPU transfer start
    input  logic                 rnW,
    input  logic [1:0]           siz,
    input  logic [1:0]           addr,
    input  logic [dataWidth-1:0] cpuWrData,
    input  logic [1:0]           dsack,
    input  logic [dataWidth-1:0] tgtRdData,
    input  writeBeat_t           wrHead,     // Oldest buffered write
    input  logic                 ackFull,
    output logic                 nTgtTs,
    output logic                 tgtA1,
    output logic [dataWidth-1:0] tgtWrData,
    output logic                 ackPush,
    output readBeat_t            ackBeat,
    output logic                 wrPush,
    output writeBeat_t           wrBeat,
    output logic                 wrPop
);

    typedef enum logic [1:0] {idle, longCycle, lowerWord, shortCycle} seqState_t;

    seqState_t             state;
    logic [1:0]            sizReg;       // Size of the running cycle
    logic                  isRead;
    lineCount_t            beatCount;
    logic                  secondStart;  // Internal start of the lower word
    logic [halfWidth-1:0]  upperHalf;    // First half of a split read
    logic                  cycleStart;
    logic                  term;
    logic                  lastBeat;
    logic                  finalTerm;
    logic                  splitLanes;
    writeBeat_t            wrSrc;

    assign cycleStart = (state == idle) && !nTs;
    assign term       = (dsack == dsackLong) || (dsack == dsackWord);  // 10 counts as wait
    assign lastBeat   = (sizReg != sizLine) || (beatCount == lastLineBeat);
    assign nTgtTs     = nTs && !secondStart;  // CPU start passes straight through

    // Last termination of the whole CPU cycle
    always_comb begin
        case (state)
            longCycle:             finalTerm = (dsack == dsackLong) && lastBeat;
            lowerWord, shortCycle: finalTerm = term;
            default:               finalTerm = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Beat pushes
    //////////////////////////////////////////////////////////////////////

    // Every line beat gets its own acknowledge
    assign ackPush = ((state == longCycle) && (dsack == dsackLong))
                   || (((state == lowerWord) || (state == shortCycle)) && term);

    always_comb begin
        ackBeat.inhibit = (state == lowerWord);  // Only split cycles inhibit bursts
        if (!isRead)
            ackBeat.data = '0;
        else if (state == lowerWord)
            ackBeat.data = {upperHalf, tgtRdData[dataWidth-1 -: halfWidth]};
        else if ((state == shortCycle) && (dsack == dsackWord))
            ackBeat.data = {2{tgtRdData[dataWidth-1 -: halfWidth]}};  // Mirror port word
        else
            ackBeat.data = tgtRdData;
    end

    assign wrPush = cycleStart && !rnW;
    assign wrBeat = '{data: cpuWrData, siz: siz, addr: addr};
    assign wrPop  = finalTerm && !isRead;  // Write word retires with the cycle

    // Write lane steering; the FIFO is still empty in the start cycle
    assign wrSrc      = (state == idle) ? wrBeat : wrHead;
    assign splitLanes = (state == lowerWord)
                      || ((wrSrc.siz inside {sizByte, sizWord}) && wrSrc.addr[1]);
    assign tgtWrData  = splitLanes ? {2{wrSrc.data[halfWidth-1:0]}} : wrSrc.data;

    //////////////////////////////////////////////////////////////////////
    // Cycle FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state       <= idle;
            sizReg      <= sizLong;
            isRead      <= 1'b1;
            beatCount   <= '0;
            secondStart <= 1'b0;
            tgtA1       <= 1'b0;
        end else begin
            secondStart <= 1'b0;                      // One cycle pulse
            case (state)
                idle: begin
                    if (!nTs) begin
                        sizReg    <= siz;
                        isRead    <= rnW;
                        beatCount <= '0;
                        state     <= (siz == sizLong || siz == sizLine) ? longCycle : shortCycle;
                    end
                end
                longCycle: begin
                    if (dsack == dsackWord) begin     // 16-bit port, go fetch lower word
                        state       <= lowerWord;
                        secondStart <= 1'b1;
                        tgtA1       <= 1'b1;
                    end else if (dsack == dsackLong) begin
                        if (lastBeat)
                            state <= idle;
                        else
                            beatCount <= beatCount + 1'b1;
                    end
                end
                lowerWord: begin
                    if (term) begin
                        state <= idle;
                        tgtA1 <= 1'b0;
                    end
                end
                default: begin                        // shortCycle
                    if (term)
                        state <= idle;
                end
            endcase
        end
    end

    // Upper half held across the second start
    always_ff @(posedge BCLK) begin
        if ((state == longCycle) && (dsack == dsackWord))
            upperHalf <= tgtRdData[dataWidth-1 -: halfWidth];
    end

    // Line cycles are only issued to 32-bit ports
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (state == longCycle && sizReg == sizLine) |-> (dsack != dsackWord))
        else $error("16-bit port answered a line cycle");

    // Target stays quiet between cycles
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (state == idle) |-> (dsack == dsackWait))
        else $error("dsack asserted with no cycle running");

    // CPU waits for its last nTa, so the ack FIFO has room at every start
    assert property (@(posedge BCLK) disable iff (!nRESET) cycleStart |-> !ackFull)
        else $error("Cycle start with ack FIFO full");

endmodule

//--- design/ackGenerator.sv
//////////////////////////////////////////////////////////////////////
// CPU acknowledge; nTa is low for one cycle per beat
// At least one high cycle always separates two acknowledges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ackGenerator
    import busSizingPkg::*;
(
    input  logic                 BCLK,
    input  logic                 nRESET,
    input  logic                 ackEmpty,
    input  readBeat_t            ackHead,
    output logic                 ackPop,
    output logic                 nTa,
    output logic                 nTbi,
    output logic [dataWidth-1:0] cpuRdData
);

    typedef enum logic [1:0] {ackIdle, ackAssert, ackNegate} ackState_t;

    ackState_t state;

    assign ackPop = (state == ackIdle) && !ackEmpty;   // Take the beat when ready

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= ackIdle;
            nTa   <= 1'b1;
            nTbi  <= 1'b1;
        end else begin
            case (state)
                ackIdle: begin
                    if (!ackEmpty) begin
                        state <= ackAssert;
                        nTa   <= 1'b0;
                        nTbi  <= !ackHead.inhibit;
                    end
                end
                ackAssert: begin                       // Single low cycle
                    state <= ackNegate;
                    nTa   <= 1'b1;
                    nTbi  <= 1'b1;
                end
                default: begin
                    state <= ackIdle;                  // Extra high cycle
                end
            endcase
        end
    end

    // Read data held for the whole nTa low cycle
    always_ff @(posedge BCLK) begin
        if (ackPop)
            cpuRdData <= ackHead.data;
    end

    // Burst inhibit is only meaningful alongside nTa
    assert property (@(posedge BCLK) disable iff (!nRESET) !nTbi |-> !nTa)
        else $error("nTbi low without nTa");

endmodule

//--- design/busGrantTracker.sv
//////////////////////////////////////////////////////////////////////
// CPU data buffer enable held from bus grant until nBb releases
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module busGrantTracker (
    input  logic BCLK,
    input  logic nRESET,
    input  logic nBg,        // Bus grant to the CPU
    input  logic nBb,        // Bus busy from the current master
    input  logic rnW,
    output logic nCpuBufEn,
    output logic bufDir      // High drives toward the CPU
);

    logic cpuOwnsBus;

    // Grant may drop mid cycle; ownership lasts until busy negates
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cpuOwnsBus <= 1'b0;
        end else begin
            if (!nBg)
                cpuOwnsBus <= 1'b1;
            else if (nBb)
                cpuOwnsBus <= 1'b0;     // Master done with the bus
        end
    end

    assign nCpuBufEn = !cpuOwnsBus;

    // CPU reads, or an alternate master writes while grant is away
    assign bufDir = (rnW && cpuOwnsBus) || (!rnW && nBg);

endmodule

//--- design/busSizer.sv
//////////////////////////////////////////////////////////////////////
// Dynamic bus sizing bridge, CPU local bus to 32/16-bit target ports
// Buses are split into in and out ports; no tri-state pins here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module busSizer
    import busSizingPkg::*;
(
    input  logic                 BCLK,
    input  logic                 nRESET,
    // CPU side
    input  logic                 nTs,
    input  logic                 rnW,
    input  logic [1:0]           siz,
    input  logic [1:0]           addr,
    input  logic [dataWidth-1:0] cpuWrData,
    output logic                 nTa,
    output logic                 nTbi,
    output logic [dataWidth-1:0] cpuRdData,
    // Target side
    output logic                 nTgtTs,
    output logic                 tgtA1,
    output logic [dataWidth-1:0] tgtWrData,
    input  logic [1:0]           dsack,
    input  logic [dataWidth-1:0] tgtRdData,
    // Bus arbitration
    input  logic                 nBg,
    input  logic                 nBb,
    output logic                 nCpuBufEn,
    output logic                 bufDir
);

    logic       ackPush;
    logic       ackPop;
    logic       ackEmpty;
    logic       ackFull;
    readBeat_t  ackBeat;
    readBeat_t  ackHead;
    logic       wrPush;
    logic       wrPop;
    writeBeat_t wrBeat;
    writeBeat_t wrHead;

    //////////////////////////////////////////////////////////////////////
    // Target cycle side
    //////////////////////////////////////////////////////////////////////

    cycleSequencer sequencer (
        .BCLK, .nRESET, .nTs, .rnW, .siz, .addr, .cpuWrData,
        .dsack, .tgtRdData, .wrHead, .ackFull,
        .nTgtTs, .tgtA1, .tgtWrData,
        .ackPush, .ackBeat, .wrPush, .wrBeat, .wrPop
    );

    // One entry per CPU acknowledge
    stagingFifo #(.payload_t(readBeat_t), .depth(ackDepth)) ackFifo (
        .BCLK, .nRESET,
        .push(ackPush), .pushData(ackBeat), .pop(ackPop),
        .headData(ackHead), .empty(ackEmpty), .full(ackFull)
    );

    // Write word held until its final termination
    stagingFifo #(.payload_t(writeBeat_t), .depth(wrDepth)) wrFifo (
        .BCLK, .nRESET,
        .push(wrPush), .pushData(wrBeat), .pop(wrPop),
        .headData(wrHead), .empty(), .full()
    );

    // CPU side
    ackGenerator acker (
        .BCLK, .nRESET, .ackEmpty, .ackHead,
        .ackPop, .nTa, .nTbi, .cpuRdData
    );

    busGrantTracker grantTracker (
        .BCLK, .nRESET, .nBg, .nBb, .rnW,
        .nCpuBufEn, .bufDir
    );

endmodule

//--- dv/busSizerTb.sv
//////////////////////////////////////////////////////////////////////
// Table-driven testbench; target model answers as a 32 or 16-bit port
// Byte ports and transfer errors are not modelled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module busSizerTb
    import busSizingPkg::*;
();

    localparam int clkPeriod     = 100;
    localparam int numRows       = 10;
    localparam int timeoutCycles = 16 + 40 * numRows + 40;  // Reset, rows, grant steps

    // One CPU cycle with everything the target model and the checks need
    typedef struct packed {
        logic [1:0]       siz;
        logic [1:0]       addr;
        logic             rnW;
        logic             port16;      // Target answers as a 16-bit port
        int               waits;       // Wait cycles before each termination
        logic [3:0][31:0] tgtWords;    // Target data in beat order
        logic [31:0]      wrData;
        int               expAcks;
        int               expStarts;
        logic             expInhibit;
        logic [3:0][31:0] expRdData;
        logic [1:0][31:0] expTgtWr;    // tgtWrData at each target start
    } stimRow_t;

    logic        BCLK = 1'b0;
    logic        nRESET, nTs, rnW, nBg, nBb;
    logic [1:0]  siz, addr, dsack;
    logic [31:0] cpuWrData, tgtRdData;
    logic        nTa, nTbi, nTgtTs, tgtA1, nCpuBufEn, bufDir;
    logic [31:0] cpuRdData, tgtWrData;

    stimRow_t    stimTable [numRows];
    stimRow_t    curRow;               // Row being run, read by the target model
    int          rowCount;
    int          seed;
    int          checkErrors;
    int          spacingErrors;
    int          startCount;           // Running totals, index the records below
    int          ackCount;
    logic [31:0] seenWr [64];
    logic        seenA1 [64];
    logic [31:0] seenRd [64];
    logic        seenTbi [64];

    busSizer UUT (.*);

    always #(clkPeriod / 2) BCLK = ~BCLK;

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        checkErrors++;
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
    endtask

    // One table row with random data and its expected results
    task automatic addRow(input logic [1:0] rowSiz, input logic [1:0] rowAddr,
                          input logic rowRnW, input logic rowPort16, input int rowWaits);
        stimRow_t r;
        r = '0;
        r.siz    = rowSiz;
        r.addr   = rowAddr;
        r.rnW    = rowRnW;
        r.port16 = rowPort16;
        r.waits  = rowWaits;
        for (int i = 0; i < lineBeats; i++)
            r.tgtWords[i] = $random(seed);
        r.wrData    = $random(seed);
        r.expStarts = 1;
        r.expAcks   = (rowSiz == sizLine) ? lineBeats : 1;
        if (rowSiz == sizLine || !rowPort16) begin
            r.expRdData = r.tgtWords;                 // One target word per acknowledge
        end else if (rowSiz == sizLong) begin
            r.expRdData[0] = r.tgtWords[0];           // Upper port word, then lower
            r.expStarts    = 2;
            r.expInhibit   = 1'b1;
        end else begin
            r.expRdData[0] = {2{r.tgtWords[0][31:16]}};
        end
        if (!rowRnW)
            r.expRdData = '0;                         // Write acks carry no data
        r.expTgtWr[0] = r.wrData;
        r.expTgtWr[1] = {2{r.wrData[15:0]}};          // Lower word steered up
        stimTable[rowCount] = r;
        rowCount++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Target port model and acknowledge monitor
    //////////////////////////////////////////////////////////////////////

    initial begin : targetPort
        int          beats;
        logic        a1;
        logic [15:0] half;
        dsack      = dsackWait;
        tgtRdData  = '0;
        startCount = 0;
        forever begin
            @(posedge BCLK);
            if (nRESET && !nTgtTs) begin
                a1 = tgtA1;
                seenA1[startCount] = tgtA1;
                seenWr[startCount] = tgtWrData;
                startCount++;
                beats = (curRow.siz == sizLine) ? lineBeats : 1;
                @(negedge BCLK);
                for (int b = 0; b < beats; b++) begin
                    repeat (curRow.waits) @(negedge BCLK);
                    if (curRow.port16) begin
                        half      = a1 ? curRow.tgtWords[0][15:0] : curRow.tgtWords[0][31:16];
                        tgtRdData = {half, ~half};    // Port word sits on the upper lanes
                        dsack     = dsackWord;
                    end else begin
                        tgtRdData = curRow.tgtWords[b];
                        dsack     = dsackLong;
                    end
                    @(negedge BCLK);
                    dsack = dsackWait;
                end
            end
        end
    end

    initial begin : ackMonitor
        logic prevTa;
        ackCount      = 0;
        spacingErrors = 0;
        prevTa        = 1'b1;
        forever begin
            @(posedge BCLK);
            if (nRESET && !nTa) begin
                if (!prevTa) begin                    // No high cycle since the last one
                    spacingErrors++;
                    $display("nTa stayed low for more than one cycle at %0t ns", $time);
                end
                seenRd[ackCount]  = cpuRdData;
                seenTbi[ackCount] = nTbi;
                ackCount++;
            end
            prevTa = nTa;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Row and grant sequences
    //////////////////////////////////////////////////////////////////////

    task automatic runRow(input int idx);
        int startBase;
        int ackBase;
        int starts;
        int acks;
        startBase = startCount;
        ackBase   = ackCount;
        curRow    = stimTable[idx];
        @(negedge BCLK);
        siz       = curRow.siz;
        addr      = curRow.addr;
        rnW       = curRow.rnW;
        cpuWrData = curRow.wrData;
        nTs       = 1'b0;
        @(negedge BCLK);
        nTs = 1'b1;                                   // One-cycle start pulse
        while (ackCount - ackBase < curRow.expAcks)
            @(negedge BCLK);
        repeat (3) @(negedge BCLK);                   // A stray acknowledge shows up here
        starts = startCount - startBase;
        acks   = ackCount - ackBase;
        if (starts != curRow.expStarts)
            reportMismatch("target starts", curRow.expStarts, starts);
        for (int s = 0; s < starts && s < curRow.expStarts; s++) begin
            if (seenA1[startBase + s] !== (s == 1))
                reportMismatch("tgtA1", 32'(s == 1), 32'(seenA1[startBase + s]));
            if (!curRow.rnW && seenWr[startBase + s] !== curRow.expTgtWr[s])
                reportMismatch("tgtWrData", curRow.expTgtWr[s], seenWr[startBase + s]);
        end
        if (acks != curRow.expAcks)
            reportMismatch("nTa count", curRow.expAcks, acks);
        for (int a = 0; a < acks && a < curRow.expAcks; a++) begin
            if (seenRd[ackBase + a] !== curRow.expRdData[a])
                reportMismatch("cpuRdData", curRow.expRdData[a], seenRd[ackBase + a]);
            if (seenTbi[ackBase + a] !== !curRow.expInhibit)
                reportMismatch("nTbi", 32'(!curRow.expInhibit), 32'(seenTbi[ackBase + a]));
        end
    endtask

    // Steps hold nBg, nBb, rnW, then expected nCpuBufEn and bufDir
    task automatic checkGrant();
        logic [4:0] steps [6];
        steps[0] = 5'b111_10;                         // Idle bus, buffers off
        steps[1] = 5'b011_01;                         // Granted, CPU reads
        steps[2] = 5'b000_00;                         // Busy, CPU writes
        steps[3] = 5'b101_01;                         // Grant gone, still busy
        steps[4] = 5'b110_11;                         // Released, other master writes
        steps[5] = 5'b111_10;
        for (int i = 0; i < 6; i++) begin
            @(negedge BCLK);
            nBg = steps[i][4];
            nBb = steps[i][3];
            rnW = steps[i][2];
            @(negedge BCLK);
            if (nCpuBufEn !== steps[i][1])
                reportMismatch("nCpuBufEn", 32'(steps[i][1]), 32'(nCpuBufEn));
            if (bufDir !== steps[i][0])
                reportMismatch("bufDir", 32'(steps[i][0]), 32'(bufDir));
        end
    endtask

    initial begin : stimulus
        nRESET      = 1'b0;
        nTs         = 1'b1;
        rnW         = 1'b1;
        siz         = sizLong;
        addr        = 2'b00;
        cpuWrData   = '0;
        nBg         = 1'b1;
        nBb         = 1'b1;
        seed        = 32'hdec6;
        rowCount    = 0;
        checkErrors = 0;
        addRow(sizLong, 2'd0, 1'b1, 1'b0, 0);
        addRow(sizLong, 2'd0, 1'b1, 1'b0, 2);
        addRow(sizLong, 2'd0, 1'b1, 1'b1, 0);         // Split read
        addRow(sizLong, 2'd0, 1'b1, 1'b1, 1);
        addRow(sizLong, 2'd0, 1'b0, 1'b1, 0);         // Split write
        addRow(sizLong, 2'd0, 1'b0, 1'b0, 1);
        addRow(sizLine, 2'd0, 1'b1, 1'b0, 0);
        addRow(sizLine, 2'd0, 1'b1, 1'b0, 1);
        addRow(sizByte, 2'd1, 1'b1, 1'b1, 0);
        addRow(sizWord, 2'd2, 1'b1, 1'b1, 2);
        repeat (16) @(negedge BCLK);
        nRESET = 1'b1;
        @(negedge BCLK);
        if (nTa !== 1'b1)
            reportMismatch("nTa after reset", 1, 32'(nTa));
        if (nTbi !== 1'b1)
            reportMismatch("nTbi after reset", 1, 32'(nTbi));
        if (nTgtTs !== 1'b1)
            reportMismatch("nTgtTs after reset", 1, 32'(nTgtTs));
        if (tgtA1 !== 1'b0)
            reportMismatch("tgtA1 after reset", 0, 32'(tgtA1));
        if (nCpuBufEn !== 1'b1)
            reportMismatch("nCpuBufEn after reset", 1, 32'(nCpuBufEn));
        for (int i = 0; i < numRows; i++)
            runRow(i);
        checkGrant();
        $display("Check errors: %0d, nTa spacing errors: %0d", checkErrors, spacingErrors);
        if (checkErrors == 0 && spacingErrors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin : watchdog
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- busSizer.f
design/busSizingPkg.sv
design/stagingFifo.sv
design/cycleSequencer.sv
design/ackGenerator.sv
design/busGrantTracker.sv
design/busSizer.sv
dv/busSizerTb.sv

//--- Makefile
# Verilator build and run for the bus sizer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= busSizerTb
FILELIST  ?= busSizer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
